// ==== build.f ====
source/dbg_bridge_pkg.sv
source/dbg_op_if.sv
source/dbg_toggle_syncflop.sv
source/dbg_cmd_decode.sv
source/dbg_bus_execute.sv
source/dbg_result_return.sv
source/dbg_bridge_top.sv
verif/dbg_bridge_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the debug bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f build.f --top-module dbg_bridge_tb --Mdir obj_dir -o dbg_bridge_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/dbg_bridge_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi
exit 0

// ==== verif/dbg_bridge_tb.sv ====
// Debug bridge testbench
`timescale 1ns/1ns
`default_nettype none

module dbg_bridge_tb import dbg_bridge_pkg::*; ();

  localparam int ACK_TIMEOUT = 40;
  localparam int NUM_VECS    = 21;

  typedef struct packed {
    logic [2:0]        op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] exp_rdata;
    logic              exp_err;
  } vec_t;

  // op, addr, wdata, expected rdata, expected err
  vec_t vecs [NUM_VECS] = '{
    '{OP_WR32, 32'h10, 32'h1234_5678, 32'h0, 1'b0},
    '{OP_RD32, 32'h10, 32'h0, 32'h1234_5678, 1'b0},
    // One lane per word with junk in the upper wdata bytes
    '{OP_WR8, 32'h20, 32'h7777_77AA, 32'h0, 1'b0},
    '{OP_RD32, 32'h20, 32'h0, 32'h1818_18AA, 1'b0},
    '{OP_WR8, 32'h25, 32'h7777_77BB, 32'h0, 1'b0},
    '{OP_RD32, 32'h24, 32'h0, 32'h1919_BB19, 1'b0},
    '{OP_WR8, 32'h2A, 32'h7777_77CC, 32'h0, 1'b0},
    '{OP_RD32, 32'h28, 32'h0, 32'h1ACC_1A1A, 1'b0},
    '{OP_WR8, 32'h2F, 32'h7777_77DD, 32'h0, 1'b0},
    '{OP_RD32, 32'h2C, 32'h0, 32'hDD1B_1B1B, 1'b0},
    '{OP_RD8, 32'h20, 32'h0, 32'h0000_00AA, 1'b0},
    '{OP_RD8, 32'h25, 32'h0, 32'h0000_00BB, 1'b0},
    '{OP_RD8, 32'h2A, 32'h0, 32'h0000_00CC, 1'b0},
    '{OP_RD8, 32'h2F, 32'h0, 32'h0000_00DD, 1'b0},
    // Rejected commands
    '{3'd4, 32'h10, 32'h0, 32'h0, 1'b1},
    '{3'd5, 32'h10, 32'h0, 32'h0, 1'b1},
    '{3'd6, 32'h10, 32'h0, 32'h0, 1'b1},
    '{3'd7, 32'h10, 32'h0, 32'h0, 1'b1},
    '{OP_RD32, 32'h13, 32'h0, 32'h0, 1'b1},
    '{OP_WR32, 32'h06, 32'hFFFF_FFFF, 32'h0, 1'b1},
    // Word untouched by the misaligned write and err low again
    '{OP_RD32, 32'h04, 32'h0, 32'h1111_1111, 1'b0}
  };

  logic              DEST_CLK;
  logic              RESET;
  logic              req_toggle;
  logic [2:0]        cmd_op;
  logic [ADDR_W-1:0] cmd_addr;
  logic [DATA_W-1:0] cmd_wdata;
  logic              busy;
  logic              done_toggle;
  logic              err;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [DATA_W-1:0] rdata;
  logic [DATA_W-1:0] wb_dat_w;
  logic [ADDR_W-1:0] wb_adr;
  logic [SEL_W-1:0]  wb_sel;
  logic [DATA_W-1:0] wb_dat_r = '0;
  logic              wb_ack   = 1'b0;

  dbg_bridge_top u_dut (.*);

  initial begin
    DEST_CLK = 1'b0;
    forever #4 DEST_CLK = ~DEST_CLK;
  end

  function automatic logic [DATA_W-1:0] lane_mask(input logic [SEL_W-1:0] sel);
    return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
  endfunction

  // Bus request expected for a command with unwritten lanes zeroed
  function automatic dbg_op_t expect_op(input vec_t v);
    dbg_op_t e;
    e.we      = (v.op == OP_WR32) || (v.op == OP_WR8);
    e.byte_op = (v.op == OP_RD8) || (v.op == OP_WR8);
    e.adr     = {v.addr[ADDR_W-1:2], 2'b00};
    e.sel     = e.byte_op ? 4'b0001 << v.addr[1:0] : 4'b1111;
    e.wdat    = e.byte_op ? {4{v.wdata[7:0]}} : v.wdata;
    e.wdat    = e.we ? e.wdat & lane_mask(e.sel) : '0;
    return e;
  endfunction

  //////////////////////////////////////////////////
  // Wishbone memory model
  //////////////////////////////////////////////////

  logic [DATA_W-1:0] mem [64];
  integer            seed = 32'h72da_7618;
  int                wait_left;
  logic              wait_armed;

  always @(posedge DEST_CLK) begin
    if (RESET) begin
      // Fill value from the whole word index
      for (int i = 0; i < 64; i++) begin
        mem[i] = 32'h0101_0101 * (i + 16);
      end
      wait_armed = 1'b0;
      wb_ack    <= 1'b0;
    end else begin
      wb_ack <= 1'b0;
      if (wb_stb && !wb_ack) begin
        // Pick 0 to 3 wait cycles once per access
        if (!wait_armed) begin
          wait_left  = $random(seed) & 3;
          wait_armed = 1'b1;
        end
        if (wait_left == 0) begin
          wb_ack    <= 1'b1;
          wb_dat_r  <= mem[wb_adr[7:2]];
          wait_armed = 1'b0;
          if (wb_we) begin
            mem[wb_adr[7:2]] = (mem[wb_adr[7:2]] & ~lane_mask(wb_sel))
                             | (wb_dat_w & lane_mask(wb_sel));
          end
        end else begin
          wait_left--;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp)
      stop_on_error($sformatf("mismatch %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("mismatch %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_bus(input dbg_op_t got, input dbg_op_t exp);
    if (got !== exp)
      stop_on_error($sformatf("mismatch wb bus got %h expected %h", got, exp));
  endtask

  // Bus monitor on the falling edge
  int                cyc_count   = 0;
  int                flip_count  = 0;
  logic              done_last   = 1'b0;
  logic              stb_waiting = 1'b0;
  logic [ADDR_W-1:0] held_adr;
  logic [DATA_W-1:0] held_dat;
  dbg_op_t           obs_op;

  always @(negedge DEST_CLK) begin
    if (wb_cyc) cyc_count++;
    if (done_toggle != done_last) flip_count++;
    done_last = done_toggle;
    // Request frozen through wait states
    if (stb_waiting) begin
      check_flag("wb_stb", wb_stb, 1'b1);
      check_data("wb_adr", wb_adr, held_adr);
      check_data("wb_dat_w", wb_dat_w, held_dat);
    end
    stb_waiting = wb_stb && !wb_ack;
    held_adr    = wb_adr;
    held_dat    = wb_dat_w;
    if (wb_stb && wb_ack) begin
      obs_op.we      = wb_we;
      obs_op.sel     = wb_sel;
      obs_op.adr     = wb_adr;
      obs_op.wdat    = wb_we ? wb_dat_w & lane_mask(wb_sel) : '0;
      obs_op.byte_op = (wb_sel != 4'b1111);
    end
  end

  // Poll busy or done_toggle until it reaches level
  task automatic wait_level(input string name, input logic level);
    int cycles;
    cycles = 0;
    do begin
      @(negedge DEST_CLK);
      cycles++;
      if (cycles > ACK_TIMEOUT)
        stop_on_error($sformatf("timeout waiting for %s to reach %0d", name, level));
    end while ((name == "busy" ? busy : done_toggle) !== level);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int   cyc_start;
    int   flip_start;
    logic done_start;
    RESET      = 1'b1;
    req_toggle = 1'b0;
    cmd_op     = 3'd0;
    cmd_addr   = '0;
    cmd_wdata  = '0;
    repeat (5) @(posedge DEST_CLK);
    RESET <= 1'b0;
    @(negedge DEST_CLK);
    check_flag("busy", busy, 1'b0);
    check_flag("err", err, 1'b0);
    check_flag("done_toggle", done_toggle, 1'b0);
    check_flag("wb_cyc", wb_cyc, 1'b0);
    check_flag("wb_stb", wb_stb, 1'b0);
    foreach (vecs[i]) begin
      cyc_start  = cyc_count;
      flip_start = flip_count;
      done_start = done_toggle;
      @(posedge DEST_CLK);
      cmd_op     <= vecs[i].op;
      cmd_addr   <= vecs[i].addr;
      cmd_wdata  <= vecs[i].wdata;
      req_toggle <= ~req_toggle;
      wait_level("busy", 1'b1);
      wait_level("done_toggle", ~done_start);
      // Still pending in the cycle the done flip shows
      check_flag("busy", busy, 1'b1);
      wait_level("busy", 1'b0);
      check_data("rdata", rdata, vecs[i].exp_rdata);
      check_flag("err", err, vecs[i].exp_err);
      // Rejected commands never reach the bus
      check_flag("wb_cyc seen", cyc_count != cyc_start, !vecs[i].exp_err);
      check_data("done_toggle flips", flip_count - flip_start, 1);
      if (!vecs[i].exp_err) check_bus(obs_op, expect_op(vecs[i]));
    end
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/dbg_bridge_top.sv ====
// Debug bridge destination side
`timescale 1ns/1ns
`default_nettype none

module dbg_bridge_top import dbg_bridge_pkg::*; (
  input  logic              DEST_CLK,
  input  logic              RESET,
  // Host side
  input  logic              req_toggle,
  input  logic [2:0]        cmd_op,
  input  logic [ADDR_W-1:0] cmd_addr,
  input  logic [DATA_W-1:0] cmd_wdata,
  output logic              busy,
  output logic              done_toggle,
  output logic [DATA_W-1:0] rdata,
  output logic              err,
  // Wishbone side
  output logic              wb_cyc,
  output logic              wb_stb,
  output logic              wb_we,
  output logic [ADDR_W-1:0] wb_adr,
  output logic [SEL_W-1:0]  wb_sel,
  output logic [DATA_W-1:0] wb_dat_w,
  input  logic [DATA_W-1:0] wb_dat_r,
  input  logic              wb_ack
);

  logic detect;
  logic clear;

  dbg_op_if u_op_if ();

  //////////////////////////////////////////////////
  // Pipeline of the four stages
  //////////////////////////////////////////////////

  // busy is the pending flag itself
  dbg_toggle_syncflop u_sync (
    .DEST_CLK (DEST_CLK), .RESET (RESET), .toggle_in (req_toggle),
    .clear (clear), .detect (detect), .pending (busy)
  );

  dbg_cmd_decode u_decode (
    .DEST_CLK (DEST_CLK), .RESET (RESET), .detect (detect),
    .cmd_op (dbg_opcode_e'(cmd_op)), .cmd_addr (cmd_addr),
    .cmd_wdata (cmd_wdata), .op_bus (u_op_if.decode_mp)
  );

  dbg_bus_execute u_execute (
    .DEST_CLK (DEST_CLK), .RESET (RESET), .op_bus (u_op_if.execute_mp),
    .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
    .wb_sel (wb_sel), .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack)
  );

  dbg_result_return u_result (
    .DEST_CLK (DEST_CLK), .RESET (RESET), .op_bus (u_op_if.result_mp),
    .clear (clear), .done_toggle (done_toggle), .rdata (rdata), .err (err)
  );

endmodule

`default_nettype wire

// ==== source/dbg_result_return.sv ====
// Result capture and done toggle
`timescale 1ns/1ns
`default_nettype none

module dbg_result_return import dbg_bridge_pkg::*; (
  input  logic              DEST_CLK,
  input  logic              RESET,
  dbg_op_if.result_mp       op_bus,
  output logic              clear,
  output logic              done_toggle,
  output logic [DATA_W-1:0] rdata,
  output logic              err
);

  logic             lat_we;
  logic             lat_byte;
  logic [SEL_W-1:0] lat_sel;
  logic [7:0]       lane_byte;

  // Context of the op in flight
  always_ff @(posedge DEST_CLK) begin
    if (op_bus.op_valid) begin
      lat_we   <= op_bus.op.we;
      lat_byte <= op_bus.op.byte_op;
      lat_sel  <= op_bus.op.sel;
    end
  end

  // Byte lane pick, sel is one-hot here
  always_comb begin
    case (lat_sel)
      4'b0001: lane_byte = op_bus.bus_rdat[7:0];
      4'b0010: lane_byte = op_bus.bus_rdat[15:8];
      4'b0100: lane_byte = op_bus.bus_rdat[23:16];
      4'b1000: lane_byte = op_bus.bus_rdat[31:24];
      default: lane_byte = 8'h00;
    endcase
  end

  //////////////////////////////////////////////////
  // Completion
  //////////////////////////////////////////////////

  always_ff @(posedge DEST_CLK or posedge RESET) begin
    if (RESET) begin
      clear       <= 1'b0;
      done_toggle <= 1'b0;
      err         <= 1'b0;
    end else begin
      clear <= op_bus.bus_done || op_bus.op_err;
      // One flip per finished command
      if (op_bus.bus_done || op_bus.op_err) done_toggle <= ~done_toggle;
      if (op_bus.bus_done) err <= 1'b0;
      else if (op_bus.op_err) err <= 1'b1;
    end
  end

  always_ff @(posedge DEST_CLK) begin
    if (op_bus.op_err || (op_bus.bus_done && lat_we)) rdata <= '0;
    else if (op_bus.bus_done && lat_byte) rdata <= DATA_W'(lane_byte);
    else if (op_bus.bus_done) rdata <= op_bus.bus_rdat;
  end

endmodule

`default_nettype wire

// ==== source/dbg_bus_execute.sv ====
// Single Wishbone access engine
`timescale 1ns/1ns
`default_nettype none

module dbg_bus_execute import dbg_bridge_pkg::*; (
  input  logic              DEST_CLK,
  input  logic              RESET,
  dbg_op_if.execute_mp      op_bus,
  output logic              wb_cyc,
  output logic              wb_stb,
  output logic              wb_we,
  output logic [ADDR_W-1:0] wb_adr,
  output logic [SEL_W-1:0]  wb_sel,
  output logic [DATA_W-1:0] wb_dat_w,
  input  logic [DATA_W-1:0] wb_dat_r,
  input  logic              wb_ack
);

  typedef enum logic {
    ST_IDLE,
    ST_ACTIVE
  } exec_state_e;

  exec_state_e state;

  // Cycle and strobe track the state directly
  assign wb_cyc = (state == ST_ACTIVE);
  assign wb_stb = (state == ST_ACTIVE);

  //////////////////////////////////////////////////
  // FSM and control
  //////////////////////////////////////////////////

  always_ff @(posedge DEST_CLK or posedge RESET) begin
    if (RESET) begin
      state           <= ST_IDLE;
      wb_we           <= 1'b0;
      op_bus.bus_done <= 1'b0;
    end else begin
      op_bus.bus_done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (op_bus.op_valid) begin
            state <= ST_ACTIVE;
            wb_we <= op_bus.op.we;
          end
        end
        ST_ACTIVE: begin
          // Wait states just stretch this state
          if (wb_ack) begin
            state           <= ST_IDLE;
            wb_we           <= 1'b0;
            op_bus.bus_done <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Bus payload
  //////////////////////////////////////////////////

  always_ff @(posedge DEST_CLK) begin
    if (state == ST_IDLE && op_bus.op_valid) begin
      wb_adr   <= op_bus.op.adr;
      wb_sel   <= op_bus.op.sel;
      wb_dat_w <= op_bus.op.wdat;
    end
    // Raw word kept for the lane pick in result
    if (state == ST_ACTIVE && wb_ack) op_bus.bus_rdat <= wb_dat_r;
  end

  // A new operation during an access would be dropped
  a_op_when_idle: assert property (@(posedge DEST_CLK) disable iff (RESET)
    op_bus.op_valid |-> !wb_cyc)
    else $error("new operation while a bus access is active");

endmodule

`default_nettype wire

// ==== source/dbg_cmd_decode.sv ====
// Host command decode and check
`timescale 1ns/1ns
`default_nettype none

module dbg_cmd_decode import dbg_bridge_pkg::*; (
  input  logic              DEST_CLK,
  input  logic              RESET,
  input  logic              detect,
  input  dbg_opcode_e       cmd_op,
  input  logic [ADDR_W-1:0] cmd_addr,
  input  logic [DATA_W-1:0] cmd_wdata,
  dbg_op_if.decode_mp       op_bus
);

  logic    op_known;
  logic    is_byte;
  logic    misaligned;
  dbg_op_t op_next;

  //////////////////////////////////////////////////
  // Command checks
  //////////////////////////////////////////////////

  assign op_known   = cmd_op inside {OP_RD32, OP_WR32, OP_RD8, OP_WR8};
  assign is_byte    = (cmd_op == OP_RD8) || (cmd_op == OP_WR8);
  // Only word accesses need alignment
  assign misaligned = !is_byte && (cmd_addr[1:0] != 2'b00);

  //////////////////////////////////////////////////
  // Operation build
  //////////////////////////////////////////////////

  always_comb begin
    op_next.we      = (cmd_op == OP_WR32) || (cmd_op == OP_WR8);
    op_next.adr     = {cmd_addr[ADDR_W-1:2], 2'b00};
    op_next.byte_op = is_byte;
    if (is_byte) begin
      // One lane from the low address bits
      op_next.sel  = SEL_W'(1) << cmd_addr[1:0];
      // Byte copied to every lane for sel to pick
      op_next.wdat = {SEL_W{cmd_wdata[7:0]}};
    end else begin
      op_next.sel  = '1;
      op_next.wdat = cmd_wdata;
    end
  end

  // Strobes
  always_ff @(posedge DEST_CLK or posedge RESET) begin
    if (RESET) begin
      op_bus.op_valid <= 1'b0;
      op_bus.op_err   <= 1'b0;
    end else begin
      op_bus.op_valid <= detect && op_known && !misaligned;
      op_bus.op_err   <= detect && (!op_known || misaligned);
    end
  end

  // Operation held until next request
  always_ff @(posedge DEST_CLK) begin
    if (detect) op_bus.op <= op_next;
  end

  // One strobe per request, needs a single-cycle detect
  a_single_strobe: assert property (@(posedge DEST_CLK) disable iff (RESET)
    (op_bus.op_valid || op_bus.op_err) |=> !(op_bus.op_valid || op_bus.op_err))
    else $error("decode strobe longer than one cycle");

endmodule

`default_nettype wire

// ==== source/dbg_toggle_syncflop.sv ====
// Toggle synchronizer with pending flag
`timescale 1ns/1ns
`default_nettype none

module dbg_toggle_syncflop (
  input  logic DEST_CLK,
  input  logic RESET,
  input  logic toggle_in,
  input  logic clear,
  output logic detect,
  output logic pending
);

  logic sync1;
  logic sync2;
  logic sync_prev;
  logic sr_flop;

  // Any change of the synced toggle is one request
  assign detect  = sync2 ^ sync_prev;
  // Flag visible in the detect cycle already
  assign pending = sr_flop | detect;

  // Two stage synchronizer plus history flop
  always_ff @(posedge DEST_CLK or posedge RESET) begin
    if (RESET) begin
      sync1     <= 1'b0;
      sync2     <= 1'b0;
      sync_prev <= 1'b0;
    end else begin
      sync1     <= toggle_in;
      sync2     <= sync1;
      sync_prev <= sync2;
    end
  end

  // Set on detect, clear wins
  always_ff @(posedge DEST_CLK or posedge RESET) begin
    if (RESET) sr_flop <= 1'b0;
    else if (clear) sr_flop <= 1'b0;
    else if (detect) sr_flop <= 1'b1;
  end

  // Host never toggles again before done returns
  a_clear_vs_detect: assert property (@(posedge DEST_CLK) disable iff (RESET)
    !(clear && detect))
    else $error("clear and detect high in the same cycle");

endmodule

`default_nettype wire

// ==== source/dbg_op_if.sv ====
// Decode to execute to result link
`timescale 1ns/1ns
`default_nettype none

interface dbg_op_if import dbg_bridge_pkg::*; ();

  // Decode side
  logic              op_valid;
  dbg_op_t           op;
  logic              op_err;

  // Bus outcome from execute
  logic              bus_done;
  logic [DATA_W-1:0] bus_rdat;

  modport decode_mp (
    output op_valid, op, op_err
  );

  modport execute_mp (
    input  op_valid, op,
    output bus_done, bus_rdat
  );

  // Result only watches
  modport result_mp (
    input op_valid, op, op_err, bus_done, bus_rdat
  );

endinterface

`default_nettype wire

// ==== source/dbg_bridge_pkg.sv ====
// Debug bridge shared definitions
`default_nettype none

package dbg_bridge_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  // One select bit per byte lane
  localparam int SEL_W  = DATA_W / 8;

  //////////////////////////////////////////////////
  // Host command encoding
  //////////////////////////////////////////////////

  // Codes 4 to 7 are reserved and rejected by decode
  typedef enum logic [2:0] {
    OP_RD32 = 3'd0,
    OP_WR32 = 3'd1,
    OP_RD8  = 3'd2,
    OP_WR8  = 3'd3
  } dbg_opcode_e;

  // Decoded operation as seen by the bus side
  typedef struct packed {
    logic              we;
    logic [SEL_W-1:0]  sel;
    // Word aligned bus address
    logic [ADDR_W-1:0] adr;
    // Write data already on the selected lane
    logic [DATA_W-1:0] wdat;
    logic              byte_op;
  } dbg_op_t;

endpackage

`default_nettype wire
